//--- stat_sync_pkg.sv
`default_nettype none

package stat_sync_pkg;

   // Width of the APB byte address seen by the register block
   localparam int apb_addr_width = 4;

   // Byte offsets of the four 32-bit registers
   // CTRL holds the synchronizer depth and the flush control
   localparam logic [apb_addr_width-1:0] addr_ctrl    = 4'h0;
   // STATUS returns the synchronized status levels and is read only
   localparam logic [apb_addr_width-1:0] addr_status  = 4'h4;
   // PENDING returns the sticky event bits, writing ones clears them
   localparam logic [apb_addr_width-1:0] addr_pending = 4'h8;
   // MASK enables each pending bit onto irq when set to one
   localparam logic [apb_addr_width-1:0] addr_mask    = 4'hc;

   // Lowest bit of the 2-bit synchronizer mode field in CTRL
   localparam int ctrl_mode_lsb  = 0;

   // Flush bit in CTRL, holding both synchronizer stages at their reset value
   localparam int ctrl_flush_bit = 2;

   // Synchronizer mode codes
   // The input passes straight through with no register in the path
   localparam logic [1:0] sync_bypass = 2'b00;

   // The output is taken after the first register stage
   localparam logic [1:0] sync_one    = 2'b01;

   // The output is taken after the second register stage
   // Code 2'b11 is not defined and falls back to bypass
   localparam logic [1:0] sync_two    = 2'b10;

endpackage

`default_nettype wire

//--- dp_sync.sv
`default_nettype none

module dp_sync #(
   parameter int                  dp_width = 1,
   parameter logic [dp_width-1:0] dp_reset = '0
) (
   input  wire                 clk,
   input  wire                 async_reset_n,
   input  wire                 sync_reset_n,
   input  wire  [1:0]          sync_ctrl,
   input  wire  [dp_width-1:0] d,
   output logic [dp_width-1:0] o
);

   import stat_sync_pkg::*;

   logic [dp_width-1:0] dp_sync_stage_1_dout;
   logic [dp_width-1:0] dp_sync_stage_2_dout;

   // The stage instance names are long and fixed so that false-path
   // constraints and metastability-hardened flop settings can find them
   // The first stage samples the asynchronous input directly
   dp_sync_regstage #(
      .dp_width (dp_width),
      .dp_init  (dp_reset)
   ) dp_sync_stage_1 (
      .clk           (clk),
      .async_reset_n (async_reset_n),
      .sync_reset_n  (sync_reset_n),
      .d             (d),
      .o             (dp_sync_stage_1_dout)
   );

   // The second stage resolves any metastability left by the first
   dp_sync_regstage #(
      .dp_width (dp_width),
      .dp_init  (dp_reset)
   ) dp_sync_stage_2 (
      .clk           (clk),
      .async_reset_n (async_reset_n),
      .sync_reset_n  (sync_reset_n),
      .d             (dp_sync_stage_1_dout),
      .o             (dp_sync_stage_2_dout)
   );

   // Output select by mode
   // Bypass is only safe when the source already runs on clk
   always_comb begin
      case (sync_ctrl)
         sync_bypass: o = d;
         sync_one:    o = dp_sync_stage_1_dout;
         sync_two:    o = dp_sync_stage_2_dout;
         // The undefined code behaves as bypass
         default:     o = d;
      endcase
   end

endmodule

module dp_sync_regstage #(
   parameter int                  dp_width = 32,
   parameter logic [dp_width-1:0] dp_init  = '0
) (
   input  wire                 clk,
   input  wire                 async_reset_n,
   input  wire                 sync_reset_n,
   input  wire  [dp_width-1:0] d,
   output logic [dp_width-1:0] o
);

   // Asynchronous reset and synchronous flush both load the init value
   // The flush is registered control from clk, so it is safe as a sync reset
   always_ff @(posedge clk or negedge async_reset_n) begin
      if (!async_reset_n) begin
         o <= dp_init;
      end else if (!sync_reset_n) begin
         o <= dp_init;
      end else begin
         o <= d;
      end
   end

endmodule

`default_nettype wire

//--- stat_event_capture.sv
`default_nettype none

module stat_event_capture #(
   parameter int stat_width = 8
) (
   input  wire                   clk,
   input  wire                   async_reset_n,
   input  wire  [stat_width-1:0] stat_sync,
   input  wire  [stat_width-1:0] pend_clear,
   input  wire  [stat_width-1:0] irq_mask,
   output logic [stat_width-1:0] pending,
   output logic                  irq
);

   // Copy of the synchronized levels from the previous clock edge
   logic [stat_width-1:0] stat_prev;

   // One bit per line that is high now and was low at the last edge
   logic [stat_width-1:0] rise;

   // Next value of the sticky pending register
   logic [stat_width-1:0] pending_next;

   // The copy follows the synchronizer output at every edge
   // During reset the synchronizer drives its reset value, so the copy
   // holds that value when reset is released and no false edge is seen
   always_ff @(posedge clk) begin
      stat_prev <= stat_sync;
   end

   // Rising edge seen at edge k compares the current level against the
   // copy taken at edge k-1
   assign rise = stat_sync & ~stat_prev;

   // Clear first, then set
   // A rising edge in the same cycle as a clear keeps the bit set,
   // so no event can be lost to a racing software clear
   always_comb begin
      pending_next = pending & ~pend_clear;
      pending_next = pending_next | rise;
   end

   // Pending bits are sticky until software clears them
   // A line that stays high does not set its bit again after a clear
   always_ff @(posedge clk or negedge async_reset_n) begin
      if (!async_reset_n) begin
         pending <= '0;
      end else begin
         pending <= pending_next;
      end
   end

   // irq is combinational from pending and mask, so it rises in the same
   // cycle as the pending bit and drops as soon as the mask is cleared
   assign irq = |(pending & irq_mask);

   // A pending bit may only turn on at an edge where its line had a rising
   // edge, which rules out spurious set paths through the clear logic
   a_pend_set_needs_rise : assert property (
      @(posedge clk) disable iff (!async_reset_n)
         ((pending & ~$past(pending)) & ~$past(rise)) == '0
   ) else begin
      $error("pending bit set without a rising edge, pending=%h rise=%h",
             pending, $past(rise));
   end

endmodule

`default_nettype wire

//--- stat_apb_regs.sv
`default_nettype none

module stat_apb_regs #(
   parameter int stat_width = 8
) (
   input  wire                                       clk,
   input  wire                                       async_reset_n,
   input  wire                                       psel,
   input  wire                                       penable,
   input  wire                                       pwrite,
   input  wire  [stat_sync_pkg::apb_addr_width-1:0]  paddr,
   input  wire  [31:0]                               pwdata,
   input  wire  [stat_width-1:0]                     stat_sync,
   input  wire  [stat_width-1:0]                     pending,
   output logic [31:0]                               prdata,
   output logic [1:0]                                sync_ctrl,
   output logic                                      sync_reset_n,
   output logic [stat_width-1:0]                     pend_clear,
   output logic [stat_width-1:0]                     irq_mask
);

   import stat_sync_pkg::*;

   // CTRL fields
   logic [1:0] ctrl_mode;
   logic       ctrl_flush;

   // MASK register, one enable bit per status line
   logic [stat_width-1:0] mask_reg;

   // Access-cycle qualifiers
   logic wr_access;
   logic rd_access;

   // Per-register write strobes
   logic wr_ctrl;
   logic wr_pending;
   logic wr_mask;

   // There are no wait states, so every access cycle completes
   assign wr_access = psel & penable & pwrite;
   assign rd_access = psel & penable & ~pwrite;

   // Full address compare, so unaligned offsets hit nothing
   assign wr_ctrl    = wr_access && (paddr == addr_ctrl);
   assign wr_pending = wr_access && (paddr == addr_pending);
   assign wr_mask    = wr_access && (paddr == addr_mask);

   // CTRL comes out of reset as two-stage synchronization without flush
   always_ff @(posedge clk or negedge async_reset_n) begin
      if (!async_reset_n) begin
         ctrl_mode  <= sync_two;
         ctrl_flush <= 1'b0;
      end else if (wr_ctrl) begin
         ctrl_mode  <= pwdata[ctrl_mode_lsb +: 2];
         ctrl_flush <= pwdata[ctrl_flush_bit];
      end
   end

   // All lines are masked out of irq after reset
   always_ff @(posedge clk or negedge async_reset_n) begin
      if (!async_reset_n) begin
         mask_reg <= '0;
      end else if (wr_mask) begin
         mask_reg <= pwdata[stat_width-1:0];
      end
   end

   // The clear pulse lasts exactly the access cycle of a PENDING write,
   // so the bits drop at the edge that ends the access like any write
   always_comb begin
      if (wr_pending) begin
         pend_clear = pwdata[stat_width-1:0];
      end else begin
         pend_clear = '0;
      end
   end

   assign sync_ctrl    = ctrl_mode;
   // Flush drives the synchronous reset of both synchronizer stages
   assign sync_reset_n = ~ctrl_flush;
   assign irq_mask     = mask_reg;

   // Read mux, valid only in the access cycle of a read
   // Unused upper bits and unmapped offsets read as zero
   always_comb begin
      prdata = '0;
      if (rd_access) begin
         case (paddr)
            addr_ctrl: begin
               prdata[ctrl_mode_lsb +: 2] = ctrl_mode;
               prdata[ctrl_flush_bit]     = ctrl_flush;
            end
            addr_status: begin
               // In bypass mode this is a live view of the input pins
               prdata[stat_width-1:0] = stat_sync;
            end
            addr_pending: begin
               prdata[stat_width-1:0] = pending;
            end
            addr_mask: begin
               prdata[stat_width-1:0] = mask_reg;
            end
            default: begin
               prdata = '0;
            end
         endcase
      end
   end

   // An access cycle must follow a setup cycle of the same transfer
   a_apb_access_phase : assert property (
      @(posedge clk) disable iff (!async_reset_n)
         penable |-> (psel && $past(psel))
   ) else begin
      $error("penable high without psel held from setup, psel=%b", psel);
   end

endmodule

`default_nettype wire

//--- stat_sync_top.sv
`default_nettype none

module stat_sync_top #(
   parameter int                    stat_width = 8,
   parameter logic [stat_width-1:0] stat_reset = '0
) (
   input  wire                                       clk,
   input  wire                                       async_reset_n,
   input  wire                                       psel,
   input  wire                                       penable,
   input  wire                                       pwrite,
   input  wire  [stat_sync_pkg::apb_addr_width-1:0]  paddr,
   input  wire  [31:0]                               pwdata,
   output logic [31:0]                               prdata,
   input  wire  [stat_width-1:0]                     stat_in,
   output logic                                      irq
);

   // Synchronizer control from the register block
   wire [1:0]            sync_ctrl;
   wire                  sync_reset_n;

   // Status levels in the clk domain
   wire [stat_width-1:0] stat_sync;

   // Interrupt side signals between the register block and event capture
   wire [stat_width-1:0] pend_clear;
   wire [stat_width-1:0] irq_mask;
   wire [stat_width-1:0] pending;

   // Software-visible registers on APB
   stat_apb_regs #(
      .stat_width (stat_width)
   ) u_regs (
      .clk           (clk),
      .async_reset_n (async_reset_n),
      .psel          (psel),
      .penable       (penable),
      .pwrite        (pwrite),
      .paddr         (paddr),
      .pwdata        (pwdata),
      .stat_sync     (stat_sync),
      .pending       (pending),
      .prdata        (prdata),
      .sync_ctrl     (sync_ctrl),
      .sync_reset_n  (sync_reset_n),
      .pend_clear    (pend_clear),
      .irq_mask      (irq_mask)
   );

   // Brings the asynchronous status lines into the clk domain
   dp_sync #(
      .dp_width (stat_width),
      .dp_reset (stat_reset)
   ) u_sync (
      .clk           (clk),
      .async_reset_n (async_reset_n),
      .sync_reset_n  (sync_reset_n),
      .sync_ctrl     (sync_ctrl),
      .d             (stat_in),
      .o             (stat_sync)
   );

   // Rising-edge capture and masked interrupt output
   stat_event_capture #(
      .stat_width (stat_width)
   ) u_events (
      .clk           (clk),
      .async_reset_n (async_reset_n),
      .stat_sync     (stat_sync),
      .pend_clear    (pend_clear),
      .irq_mask      (irq_mask),
      .pending       (pending),
      .irq           (irq)
   );

endmodule

`default_nettype wire

//--- stat_sync_tb.sv
`default_nettype none

module stat_sync_tb;

   import stat_sync_pkg::*;

   localparam int stat_width = 8;

   // Row operations of the stimulus table
   localparam int op_write = 0;
   localparam int op_read  = 1;
   localparam int op_drive = 2;
   localparam int op_irq   = 3;
   // STATUS read with stat_in changed on the edge that opens the access cycle
   localparam int op_live  = 4;

   logic                      clk;
   logic                      async_reset_n;
   logic                      psel;
   logic                      penable;
   logic                      pwrite;
   logic [apb_addr_width-1:0] paddr;
   logic [31:0]               pwdata;
   logic [31:0]               prdata;
   logic [stat_width-1:0]     stat_in;
   logic                      irq;

   // Stimulus table, one entry per row in each queue
   int                        row_op[$];
   logic [apb_addr_width-1:0] row_addr[$];
   logic [31:0]               row_data[$];
   int                        row_idle[$];
   logic [31:0]               row_exp[$];

   int check_count  = 0;
   int prdata_errors = 0;
   int irq_errors    = 0;
   int cycle_count   = 0;
   int cycle_limit   = 0;

   stat_sync_top #(
      .stat_width (stat_width),
      .stat_reset ('0)
   ) i_dut (
      .clk           (clk),
      .async_reset_n (async_reset_n),
      .psel          (psel),
      .penable       (penable),
      .pwrite        (pwrite),
      .paddr         (paddr),
      .pwdata        (pwdata),
      .prdata        (prdata),
      .stat_in       (stat_in),
      .irq           (irq)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Free-running cycle counter that ends a stuck run
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
         $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
         report_counts();
         $display("Some tests failed");
         $finish;
      end
   end

   task automatic add_row(input int op, input logic [apb_addr_width-1:0] addr,
                          input logic [31:0] data, input int idle, input logic [31:0] exp);
      row_op.push_back(op);
      row_addr.push_back(addr);
      row_data.push_back(data);
      row_idle.push_back(idle);
      row_exp.push_back(exp);
   endtask

   // Register bits that the DUT ignores, which get random filler on writes
   function automatic logic [31:0] unused_bits(input logic [apb_addr_width-1:0] addr);
      if (addr == addr_ctrl) begin
         return ~((32'h1 << (ctrl_flush_bit + 1)) - 32'h1);
      end
      return ~((32'h1 << stat_width) - 32'h1);
   endfunction

   // Setup cycle, access cycle, and the write lands on the edge closing the access
   task automatic apb_write(input logic [apb_addr_width-1:0] addr, input logic [31:0] data);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b1;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge clk);
      penable <= 1'b1;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   // prdata is sampled mid access cycle, away from any clock edge
   task automatic apb_read(input logic [apb_addr_width-1:0] addr, input bit live,
                           input logic [31:0] live_val, output logic [31:0] data);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= addr;
      @(posedge clk);
      penable <= 1'b1;
      if (live) begin
         stat_in <= live_val[stat_width-1:0];
      end
      @(negedge clk);
      data = prdata;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic report_counts();
      $display("Checks: %0d, prdata errors: %0d, irq errors: %0d",
               check_count, prdata_errors, irq_errors);
   endtask

   initial begin
      logic [31:0] got;
      logic [31:0] noise;
      int          seed_ret;

      seed_ret      = $urandom(32'h37b423aa);
      async_reset_n = 1'b0;
      psel          = 1'b0;
      penable       = 1'b0;
      pwrite        = 1'b0;
      paddr         = '0;
      pwdata        = '0;
      stat_in       = '0;

      // Reset values, with the synchronizer in mode two
      add_row(op_read,  addr_ctrl,    0, 0, {30'h0, sync_two});
      add_row(op_read,  addr_mask,    0, 0, 32'h00);
      add_row(op_read,  addr_pending, 0, 0, 32'h00);
      add_row(op_read,  addr_status,  0, 0, 32'h00);
      add_row(op_irq,   addr_ctrl,    0, 0, 32'h0);
      // Two rising edges while everything is masked
      add_row(op_drive, addr_ctrl,    32'h05, 4, 32'h0);
      add_row(op_read,  addr_status,  0, 0, 32'h05);
      add_row(op_read,  addr_pending, 0, 0, 32'h05);
      add_row(op_irq,   addr_ctrl,    0, 0, 32'h0);
      // Unmasking an already pending line raises irq by itself
      add_row(op_write, addr_mask,    32'h04, 1, 0);
      add_row(op_irq,   addr_ctrl,    0, 0, 32'h1);
      add_row(op_read,  addr_mask,    0, 0, 32'h04);
      // Falling edge on line 2 leaves pending alone
      add_row(op_drive, addr_ctrl,    32'h01, 4, 32'h1);
      add_row(op_read,  addr_pending, 0, 0, 32'h05);
      add_row(op_write, addr_pending, 32'h04, 1, 0);
      add_row(op_read,  addr_pending, 0, 0, 32'h01);
      add_row(op_irq,   addr_ctrl,    0, 0, 32'h0);
      add_row(op_write, addr_pending, 32'h00, 1, 0);
      add_row(op_read,  addr_pending, 0, 0, 32'h01);
      // Line 0 stays high, so the clear is not undone
      add_row(op_write, addr_pending, 32'h01, 2, 0);
      add_row(op_read,  addr_pending, 0, 0, 32'h00);
      // Mode one
      add_row(op_write, addr_ctrl,    {30'h0, sync_one}, 1, 0);
      add_row(op_read,  addr_ctrl,    0, 0, {30'h0, sync_one});
      add_row(op_drive, addr_ctrl,    32'h81, 4, 32'h0);
      add_row(op_read,  addr_status,  0, 0, 32'h81);
      add_row(op_read,  addr_pending, 0, 0, 32'h80);
      add_row(op_write, addr_mask,    32'h80, 1, 0);
      add_row(op_irq,   addr_ctrl,    0, 0, 32'h1);
      // Flush in modes one and two shows the reset value
      add_row(op_write, addr_ctrl,    32'h05, 2, 0);
      add_row(op_read,  addr_status,  0, 0, 32'h00);
      add_row(op_read,  addr_ctrl,    0, 0, 32'h05);
      add_row(op_write, addr_ctrl,    32'h06, 2, 0);
      add_row(op_read,  addr_status,  0, 0, 32'h00);
      // Leaving flush brings lines 0 and 7 back up as new edges
      add_row(op_write, addr_ctrl,    {30'h0, sync_two}, 4, 0);
      add_row(op_read,  addr_status,  0, 0, 32'h81);
      add_row(op_read,  addr_pending, 0, 0, 32'h81);
      add_row(op_write, addr_pending, 32'hff, 1, 0);
      add_row(op_irq,   addr_ctrl,    0, 0, 32'h0);
      // Bypass mode
      add_row(op_write, addr_ctrl,    {30'h0, sync_bypass}, 3, 0);
      add_row(op_drive, addr_ctrl,    32'h03, 3, 32'h0);
      add_row(op_read,  addr_status,  0, 0, 32'h03);
      add_row(op_read,  addr_pending, 0, 0, 32'h02);
      add_row(op_write, addr_mask,    32'h02, 1, 0);
      add_row(op_irq,   addr_ctrl,    0, 0, 32'h1);
      add_row(op_live,  addr_status,  32'h13, 3, 32'h13);
      add_row(op_read,  addr_pending, 0, 0, 32'h12);
      add_row(op_write, addr_pending, 32'h12, 1, 0);
      add_row(op_irq,   addr_ctrl,    0, 0, 32'h0);
      // The undefined mode code acts as bypass
      // The input change on the access edge must show in the same read
      add_row(op_write, addr_ctrl,    32'h03, 1, 0);
      add_row(op_live,  addr_status,  32'h00, 3, 32'h00);
      add_row(op_read,  addr_ctrl,    0, 0, 32'h03);

      cycle_limit = 10 * row_op.size() + 10 + 50;

      repeat (10) @(posedge clk);
      async_reset_n <= 1'b1;

      for (int i = 0; i < row_op.size(); i++) begin
         case (row_op[i])
            op_write: begin
               noise = $urandom;
               apb_write(row_addr[i], row_data[i] | (noise & unused_bits(row_addr[i])));
            end
            op_read, op_live: begin
               apb_read(row_addr[i], row_op[i] == op_live, row_data[i], got);
               check_count++;
               assert (got === row_exp[i]) else begin
                  prdata_errors++;
                  $display("[ERROR] prdata row %0d: got %h, expected %h",
                           i, got, row_exp[i]);
               end
            end
            op_drive: begin
               @(posedge clk);
               stat_in <= row_data[i][stat_width-1:0];
            end
            default: begin
            end
         endcase
         repeat (row_idle[i]) @(posedge clk);
         // irq is checked once the row's idle cycles have passed
         if (row_op[i] == op_drive || row_op[i] == op_irq) begin
            @(negedge clk);
            check_count++;
            assert (irq === row_exp[i][0]) else begin
               irq_errors++;
               $display("[ERROR] irq row %0d: got %h, expected %h", i, irq, row_exp[i][0]);
            end
         end
      end

      report_counts();
      if (prdata_errors == 0 && irq_errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- stat_sync.f
stat_sync_pkg.sv
dp_sync.sv
stat_event_capture.sv
stat_apb_regs.sv
stat_sync_top.sv
stat_sync_tb.sv
